//--- source/cu_pkg.sv
package cu_pkg;

    // issue and commit width, one bit per slot in the vectors below
    localparam int ISSUE_W  = 2;
    localparam int GL_IDX_W = 6;
    localparam int CHKP_W   = 3;

    typedef enum logic [1:0] {
        NEXT_PC_BP_OR_PC4 = 2'd0,
        NEXT_PC_KEEP_PC   = 2'd1,
        NEXT_PC_JUMP      = 2'd2
    } next_pc_sel_e;

    typedef enum logic [1:0] {
        SEL_DECODE    = 2'd0,
        SEL_EXECUTION = 2'd1,
        SEL_CSR       = 2'd2,
        SEL_CSR_RW    = 2'd3
    } fetch_sel_e;

    // status coming from the pipeline stages
    typedef struct packed {
        logic valid;
        logic is_branch;
        logic predicted_as_branch;
        logic valid_jal;
        logic stall_csr_fence;
    } id_cu_t;

    typedef struct packed {
        logic [ISSUE_W-1:0] valid;
        logic [ISSUE_W-1:0] is_branch;
        logic [ISSUE_W-1:0] full_iq;
        logic               out_of_checkpoints;
        logic               empty_free_list;
    } ir_cu_t;

    typedef struct packed {
        logic gl_full;
    } rr_cu_t;

    typedef struct packed {
        logic stall;
    } exe_cu_t;

    typedef struct packed {
        logic [ISSUE_W-1:0]  valid;
        logic [ISSUE_W-1:0]  write_enable;
        // prediction outcome of the branch in slot 0
        logic                correct_pred;
        logic                checkpoint_done;
        logic [CHKP_W-1:0]   chkp;
        logic [GL_IDX_W-1:0] gl_index;
    } wb_cu_t;

    typedef struct packed {
        logic               valid;
        logic               xcpt;
        logic               ecall_taken;
        logic               stall_csr_fence;
        logic               fence;
        logic               fence_i;
        logic               write_enable;
        logic [ISSUE_W-1:0] retire;
        logic [ISSUE_W-1:0] regfile_we;
        logic               stall_commit;
    } commit_cu_t;

    typedef struct packed {
        logic csr_eret;
        logic csr_exception;
        logic csr_stall;
    } csr_cu_t;

    // control going back to the pipeline
    typedef struct packed {
        logic stall_if_1;
        logic stall_if_2;
        logic stall_id;
        logic stall_iq;
        logic stall_ir;
        logic stall_rr;
        logic stall_exe;
        logic stall_commit;
        // spare bit, always zero
        logic spare;
    } pipeline_ctrl_t;

    typedef struct packed {
        logic flush_if;
        logic flush_id;
        logic flush_ir;
        logic flush_rr;
        logic flush_exe;
        logic kill_exe;
        logic flush_commit;
    } pipeline_flush_t;

    typedef struct packed {
        next_pc_sel_e next_pc;
        fetch_sel_e   sel_addr;
        logic         invalidate_icache;
        logic         invalidate_buffer;
    } fetch_ctrl_t;

    typedef struct packed {
        logic               do_checkpoint;
        logic               do_recover;
        logic [CHKP_W-1:0]  recover_checkpoint;
        logic               delete_checkpoint;
        logic [ISSUE_W-1:0] enable_commit_update;
        logic               recover_commit;
    } cu_ir_t;

    typedef struct packed {
        logic [ISSUE_W-1:0] write_enable;
    } cu_rr_t;

    typedef struct packed {
        logic                flush_gl;
        logic [GL_IDX_W-1:0] flush_gl_index;
    } cu_wb_t;

    typedef struct packed {
        logic flush_gl_commit;
        logic enable_commit;
    } cu_commit_t;

    // decoded redirect events shared by the control blocks
    typedef struct packed {
        logic mispredict_wb;
        logic bad_pred_id;
        logic jump;
        logic xcpt_now;
        logic xcpt_q;
        logic csr_q;
        logic fence_pending;
        logic id_fence;
    } cu_event_t;

endpackage

//--- source/redirect_tracker.sv
module redirect_tracker
    import cu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  id_cu_t     id_cu_i,
    input  wb_cu_t     wb_cu_i,
    input  commit_cu_t commit_cu_i,
    input  csr_cu_t    csr_cu_i,
    output cu_event_t  event_o
);

    logic xcpt_req;
    logic xcpt_d;
    logic xcpt_q;
    logic csr_d;
    logic csr_q;
    logic fence_pending_q;
    logic commit_fence;

    // any source that sends fetch to the trap vector or the return address
    assign xcpt_req = (commit_cu_i.valid & commit_cu_i.xcpt) |
                      (commit_cu_i.valid & commit_cu_i.ecall_taken) |
                      csr_cu_i.csr_eret |
                      csr_cu_i.csr_exception;

    assign commit_fence = commit_cu_i.valid & commit_cu_i.stall_csr_fence;

    // a request while the previous one is still being served is dropped
    assign xcpt_d = ~xcpt_q & xcpt_req;
    assign csr_d  = ~csr_q & commit_fence & ~xcpt_req;

    always_comb begin
        event_o.mispredict_wb = wb_cu_i.valid[0] & ~wb_cu_i.correct_pred;
        event_o.bad_pred_id   = id_cu_i.valid & id_cu_i.predicted_as_branch &
                                ~id_cu_i.is_branch;
        event_o.jump          = event_o.mispredict_wb | event_o.bad_pred_id |
                                id_cu_i.valid_jal;
        event_o.xcpt_now      = xcpt_d;
        event_o.xcpt_q        = xcpt_q;
        event_o.csr_q         = csr_q;
        event_o.fence_pending = fence_pending_q;
        event_o.id_fence      = id_cu_i.valid & id_cu_i.stall_csr_fence;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_q <= 1'b0;
            csr_q  <= 1'b0;
        end else begin
            xcpt_q <= xcpt_d;
            csr_q  <= csr_d;
        end
    end

    // csr fence travelling between decode and commit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_pending_q <= 1'b0;
        end else if (xcpt_q || event_o.mispredict_wb) begin
            fence_pending_q <= 1'b0;
        end else if (event_o.id_fence) begin
            fence_pending_q <= 1'b1;
        end else if (commit_fence) begin
            fence_pending_q <= 1'b0;
        end
    end

endmodule

//--- source/pc_select.sv
module pc_select
    import cu_pkg::*;
(
    input  cu_event_t   event_i,
    input  commit_cu_t  commit_cu_i,
    input  logic        stall_if_1_i,
    output fetch_ctrl_t fetch_o
);

    always_comb begin
        if (event_i.jump || event_i.xcpt_q || event_i.csr_q) begin
            fetch_o.next_pc = NEXT_PC_JUMP;
        end else if (stall_if_1_i || event_i.id_fence || event_i.fence_pending ||
                     (commit_cu_i.valid && commit_cu_i.fence)) begin
            fetch_o.next_pc = NEXT_PC_KEEP_PC;
        end else begin
            fetch_o.next_pc = NEXT_PC_BP_OR_PC4;
        end
    end

    // trap and csr redirects win over a branch fix from execute
    always_comb begin
        if (event_i.xcpt_q) begin
            fetch_o.sel_addr = SEL_CSR;
        end else if (event_i.csr_q) begin
            fetch_o.sel_addr = SEL_CSR_RW;
        end else if (event_i.mispredict_wb) begin
            fetch_o.sel_addr = SEL_EXECUTION;
        end else begin
            fetch_o.sel_addr = SEL_DECODE;
        end
    end

    // fence.i may follow self modifying code
    assign fetch_o.invalidate_icache = commit_cu_i.valid & commit_cu_i.fence_i;

    assign fetch_o.invalidate_buffer = commit_cu_i.valid &
                                       (commit_cu_i.fence_i | event_i.xcpt_q |
                                        (commit_cu_i.stall_csr_fence & ~commit_cu_i.fence));

endmodule

//--- source/flush_ctrl.sv
module flush_ctrl
    import cu_pkg::*;
(
    input  cu_event_t       event_i,
    input  id_cu_t          id_cu_i,
    input  rr_cu_t          rr_cu_i,
    input  exe_cu_t         exe_cu_i,
    input  wb_cu_t          wb_cu_i,
    input  commit_cu_t      commit_cu_i,
    input  csr_cu_t         csr_cu_i,
    output pipeline_flush_t flush_o,
    output cu_wb_t          wb_ctrl_o
);

    logic fetch_redirect;

    // causes that only drop the instruction being fetched
    assign fetch_redirect = event_i.fence_pending | event_i.id_fence |
                            (commit_cu_i.valid & commit_cu_i.stall_csr_fence) |
                            (commit_cu_i.valid & commit_cu_i.fence) |
                            id_cu_i.valid_jal |
                            event_i.bad_pred_id;

    // frontend
    always_comb begin
        flush_o.flush_if = 1'b0;
        flush_o.flush_id = 1'b0;
        if (event_i.xcpt_q || event_i.csr_q || event_i.mispredict_wb) begin
            flush_o.flush_if = 1'b1;
            flush_o.flush_id = 1'b1;
        end else if (fetch_redirect && !csr_cu_i.csr_stall) begin
            flush_o.flush_if = 1'b1;
        end
    end

    // backend
    always_comb begin
        flush_o.flush_ir  = 1'b0;
        flush_o.flush_rr  = 1'b0;
        flush_o.flush_exe = 1'b0;
        flush_o.kill_exe  = 1'b0;
        if (event_i.xcpt_q) begin
            flush_o.flush_ir  = 1'b1;
            flush_o.flush_rr  = 1'b1;
            flush_o.flush_exe = 1'b1;
        end else if (event_i.mispredict_wb) begin
            // exe still holds older work, so only the wrong path is killed
            flush_o.flush_ir = 1'b1;
            flush_o.flush_rr = 1'b1;
            flush_o.kill_exe = 1'b1;
        end else if (!exe_cu_i.stall && rr_cu_i.gl_full) begin
            // insert a bubble into exe while rr waits for a gl entry
            flush_o.flush_rr = 1'b1;
        end
    end

    // commit is emptied through the graduation list flush instead
    assign flush_o.flush_commit = 1'b0;

    // drop every gl entry younger than the mispredicted branch
    always_comb begin
        if (event_i.mispredict_wb) begin
            wb_ctrl_o.flush_gl       = 1'b1;
            wb_ctrl_o.flush_gl_index = wb_cu_i.gl_index;
        end else begin
            wb_ctrl_o.flush_gl       = 1'b0;
            wb_ctrl_o.flush_gl_index = '0;
        end
    end

endmodule

//--- source/stall_ctrl.sv
module stall_ctrl
    import cu_pkg::*;
(
    input  ir_cu_t         ir_cu_i,
    input  rr_cu_t         rr_cu_i,
    input  exe_cu_t        exe_cu_i,
    input  commit_cu_t     commit_cu_i,
    input  csr_cu_t        csr_cu_i,
    input  logic           miss_icache_i,
    input  logic           ready_icache_i,
    output pipeline_ctrl_t ctrl_o
);

    // frontend
    always_comb begin
        ctrl_o.stall_if_1 = 1'b0;
        ctrl_o.stall_if_2 = 1'b0;
        ctrl_o.stall_id   = 1'b0;
        if (csr_cu_i.csr_stall || (|ir_cu_i.full_iq)) begin
            ctrl_o.stall_if_1 = 1'b1;
            ctrl_o.stall_if_2 = 1'b1;
            ctrl_o.stall_id   = 1'b1;
        end else if ((commit_cu_i.valid && commit_cu_i.stall_csr_fence) ||
                     miss_icache_i || !ready_icache_i) begin
            // only the fetch request is held, the rest drains
            ctrl_o.stall_if_1 = 1'b1;
        end
    end

    // backend, first active cause wins
    always_comb begin
        ctrl_o.stall_iq  = 1'b0;
        ctrl_o.stall_ir  = 1'b0;
        ctrl_o.stall_rr  = 1'b0;
        ctrl_o.stall_exe = 1'b0;
        if (csr_cu_i.csr_stall) begin
            ctrl_o.stall_iq  = 1'b1;
            ctrl_o.stall_ir  = 1'b1;
            ctrl_o.stall_rr  = 1'b1;
            ctrl_o.stall_exe = 1'b1;
        end else if (exe_cu_i.stall || rr_cu_i.gl_full) begin
            ctrl_o.stall_iq = 1'b1;
            ctrl_o.stall_ir = 1'b1;
            ctrl_o.stall_rr = 1'b1;
        end else if (ir_cu_i.empty_free_list || ir_cu_i.out_of_checkpoints) begin
            // rename cannot allocate, hold the queue only
            ctrl_o.stall_iq = 1'b1;
        end
    end

    assign ctrl_o.stall_commit = commit_cu_i.stall_commit;
    assign ctrl_o.spare        = 1'b0;

endmodule

//--- source/rename_commit_ctrl.sv
module rename_commit_ctrl
    import cu_pkg::*;
(
    input  cu_event_t  event_i,
    input  ir_cu_t     ir_cu_i,
    input  wb_cu_t     wb_cu_i,
    input  commit_cu_t commit_cu_i,
    input  csr_cu_t    csr_cu_i,
    input  logic       flush_ir_i,
    input  logic       stall_ir_i,
    output cu_ir_t     ir_ctrl_o,
    output cu_rr_t     rr_ctrl_o,
    output cu_commit_t commit_ctrl_o
);

    logic branch_resolved;
    logic commit_write;

    // take a snapshot of rename when a branch enters with a full pair
    assign ir_ctrl_o.do_checkpoint = (&ir_cu_i.valid) & (|ir_cu_i.is_branch) &
                                     ~ir_cu_i.out_of_checkpoints &
                                     ~flush_ir_i & ~stall_ir_i;

    assign branch_resolved = wb_cu_i.valid[0] & wb_cu_i.checkpoint_done;

    assign ir_ctrl_o.do_recover         = branch_resolved & event_i.mispredict_wb;
    assign ir_ctrl_o.delete_checkpoint  = branch_resolved & wb_cu_i.correct_pred;
    assign ir_ctrl_o.recover_checkpoint = wb_cu_i.chkp;

    // free list and rename updates stop once a trap is taken
    assign ir_ctrl_o.enable_commit_update = commit_cu_i.retire & commit_cu_i.regfile_we &
                                            {ISSUE_W{~event_i.xcpt_now}};
    assign ir_ctrl_o.recover_commit       = event_i.xcpt_q;

    assign commit_ctrl_o.flush_gl_commit = event_i.xcpt_q;
    assign commit_ctrl_o.enable_commit   = ~(commit_cu_i.stall_commit | event_i.xcpt_now);

    // slot 0 port is shared with the commit stage write
    assign commit_write = commit_cu_i.valid & commit_cu_i.write_enable &
                          ~commit_cu_i.xcpt & ~csr_cu_i.csr_exception;

    always_comb begin
        for (int i = 0; i < ISSUE_W; i++) begin
            rr_ctrl_o.write_enable[i] = wb_cu_i.valid[i] & wb_cu_i.write_enable[i];
        end
        rr_ctrl_o.write_enable[0] = rr_ctrl_o.write_enable[0] | commit_write;
    end

endmodule

//--- source/control_unit.sv
module control_unit
    import cu_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  id_cu_t          id_cu_i,
    input  ir_cu_t          ir_cu_i,
    input  rr_cu_t          rr_cu_i,
    input  exe_cu_t         exe_cu_i,
    input  wb_cu_t          wb_cu_i,
    input  commit_cu_t      commit_cu_i,
    input  csr_cu_t         csr_cu_i,
    input  logic            miss_icache_i,
    input  logic            ready_icache_i,
    output pipeline_ctrl_t  pipeline_ctrl_o,
    output pipeline_flush_t pipeline_flush_o,
    output fetch_ctrl_t     fetch_o,
    output cu_ir_t          cu_ir_o,
    output cu_rr_t          cu_rr_o,
    output cu_wb_t          cu_wb_o,
    output cu_commit_t      cu_commit_o
);

    cu_event_t cu_event;

    redirect_tracker u_redirect_tracker (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .id_cu_i     (id_cu_i),
        .wb_cu_i     (wb_cu_i),
        .commit_cu_i (commit_cu_i),
        .csr_cu_i    (csr_cu_i),
        .event_o     (cu_event)
    );

    stall_ctrl u_stall_ctrl (
        .ir_cu_i        (ir_cu_i),
        .rr_cu_i        (rr_cu_i),
        .exe_cu_i       (exe_cu_i),
        .commit_cu_i    (commit_cu_i),
        .csr_cu_i       (csr_cu_i),
        .miss_icache_i  (miss_icache_i),
        .ready_icache_i (ready_icache_i),
        .ctrl_o         (pipeline_ctrl_o)
    );

    pc_select u_pc_select (
        .event_i      (cu_event),
        .commit_cu_i  (commit_cu_i),
        .stall_if_1_i (pipeline_ctrl_o.stall_if_1),
        .fetch_o      (fetch_o)
    );

    flush_ctrl u_flush_ctrl (
        .event_i     (cu_event),
        .id_cu_i     (id_cu_i),
        .rr_cu_i     (rr_cu_i),
        .exe_cu_i    (exe_cu_i),
        .wb_cu_i     (wb_cu_i),
        .commit_cu_i (commit_cu_i),
        .csr_cu_i    (csr_cu_i),
        .flush_o     (pipeline_flush_o),
        .wb_ctrl_o   (cu_wb_o)
    );

    // checkpoint creation looks at the ir flush and stall of this cycle
    rename_commit_ctrl u_rename_commit_ctrl (
        .event_i       (cu_event),
        .ir_cu_i       (ir_cu_i),
        .wb_cu_i       (wb_cu_i),
        .commit_cu_i   (commit_cu_i),
        .csr_cu_i      (csr_cu_i),
        .flush_ir_i    (pipeline_flush_o.flush_ir),
        .stall_ir_i    (pipeline_ctrl_o.stall_ir),
        .ir_ctrl_o     (cu_ir_o),
        .rr_ctrl_o     (cu_rr_o),
        .commit_ctrl_o (cu_commit_o)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

endmodule

//--- test/tb_checker.sv
module tb_checker
    import cu_pkg::*;
(
    input  logic            clk_i,
    input  logic            check_en_i,
    input  int              row_idx_i,
    input  pipeline_ctrl_t  pipeline_ctrl_i,
    input  pipeline_flush_t pipeline_flush_i,
    input  fetch_ctrl_t     fetch_i,
    input  cu_ir_t          cu_ir_i,
    input  cu_rr_t          cu_rr_i,
    input  cu_wb_t          cu_wb_i,
    input  cu_commit_t      cu_commit_i,
    input  pipeline_ctrl_t  exp_ctrl_i,
    input  pipeline_flush_t exp_flush_i,
    input  fetch_ctrl_t     exp_fetch_i,
    input  cu_ir_t          exp_ir_i,
    input  cu_rr_t          exp_rr_i,
    input  cu_wb_t          exp_wb_i,
    input  cu_commit_t      exp_commit_i,
    output int              error_count_o,
    output int              check_count_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;
    int check_count = 0;

    assign error_count_o = error_count;
    assign check_count_o = check_count;

    task automatic compare_value(input string name, input logic [15:0] exp_val,
                                 input logic [15:0] act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] row %0d %s expected %h actual %h",
                     row_idx_i, name, exp_val, act_val);
            error_count++;
        end
    endtask

    // inputs change on the falling edge, so look 10 ns before the rising edge
    always begin
        @(negedge clk_i);
        #40;
        if (check_en_i) begin
            compare_value("pipeline_ctrl_o", exp_ctrl_i, pipeline_ctrl_i);
            compare_value("pipeline_flush_o", exp_flush_i, pipeline_flush_i);
            compare_value("fetch_o", exp_fetch_i, fetch_i);
            compare_value("cu_ir_o", exp_ir_i, cu_ir_i);
            compare_value("cu_rr_o", exp_rr_i, cu_rr_i);
            compare_value("cu_wb_o", exp_wb_i, cu_wb_i);
            compare_value("cu_commit_o", exp_commit_i, cu_commit_i);
            check_count++;
        end
    end

endmodule

//--- test/tb_control_unit.sv
module tb_control_unit;

    import cu_pkg::*;

    timeunit 1ns;
    timeprecision 100ps;

    // one cycle of stimulus together with the outputs expected in that cycle
    typedef struct packed {
        id_cu_t          id;
        ir_cu_t          ir;
        rr_cu_t          rr;
        exe_cu_t         exe;
        wb_cu_t          wb;
        commit_cu_t      commit;
        csr_cu_t         csr;
        logic            miss;
        logic            ready;
        pipeline_ctrl_t  exp_ctrl;
        pipeline_flush_t exp_flush;
        fetch_ctrl_t     exp_fetch;
        cu_ir_t          exp_ir;
        cu_rr_t          exp_rr;
        cu_wb_t          exp_wb;
        cu_commit_t      exp_commit;
    } row_t;

    logic            clk;
    logic            rstn;
    logic            check_en;
    int              row_idx;
    row_t            rows[$];
    row_t            cur;
    pipeline_ctrl_t  pipeline_ctrl;
    pipeline_flush_t pipeline_flush;
    fetch_ctrl_t     fetch;
    cu_ir_t          cu_ir;
    cu_rr_t          cu_rr;
    cu_wb_t          cu_wb;
    cu_commit_t      cu_commit;
    int              error_count;
    int              check_count;

    tb_clock clock_gen (.clk_o(clk));

    control_unit dut_i (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .id_cu_i          (cur.id),
        .ir_cu_i          (cur.ir),
        .rr_cu_i          (cur.rr),
        .exe_cu_i         (cur.exe),
        .wb_cu_i          (cur.wb),
        .commit_cu_i      (cur.commit),
        .csr_cu_i         (cur.csr),
        .miss_icache_i    (cur.miss),
        .ready_icache_i   (cur.ready),
        .pipeline_ctrl_o  (pipeline_ctrl),
        .pipeline_flush_o (pipeline_flush),
        .fetch_o          (fetch),
        .cu_ir_o          (cu_ir),
        .cu_rr_o          (cu_rr),
        .cu_wb_o          (cu_wb),
        .cu_commit_o      (cu_commit)
    );

    tb_checker result_checker (
        .clk_i (clk), .check_en_i (check_en), .row_idx_i (row_idx),
        .pipeline_ctrl_i (pipeline_ctrl), .pipeline_flush_i (pipeline_flush),
        .fetch_i (fetch), .cu_ir_i (cu_ir), .cu_rr_i (cu_rr), .cu_wb_i (cu_wb),
        .cu_commit_i (cu_commit),
        .exp_ctrl_i (cur.exp_ctrl), .exp_flush_i (cur.exp_flush),
        .exp_fetch_i (cur.exp_fetch), .exp_ir_i (cur.exp_ir), .exp_rr_i (cur.exp_rr),
        .exp_wb_i (cur.exp_wb), .exp_commit_i (cur.exp_commit),
        .error_count_o (error_count), .check_count_o (check_count)
    );

    // quiet pipeline with the icache ready, commit allowed and fetch from decode
    function automatic row_t idle_row();
        row_t r;
        r = '0;
        r.ready = 1'b1;
        r.exp_fetch.next_pc = NEXT_PC_BP_OR_PC4;
        r.exp_fetch.sel_addr = SEL_DECODE;
        r.exp_commit.enable_commit = 1'b1;
        return r;
    endfunction

    // stall bit order is if1 if2 id iq ir rr exe commit spare
    // flush bit order is if id ir rr exe kill commit
    task automatic build_table();
        row_t r;
        rows.push_back(idle_row());
        // writeback mispredict with a checkpoint to recover
        r = idle_row();
        r.wb.valid = 2'b01;
        r.wb.checkpoint_done = 1'b1;
        r.wb.chkp = 3'd5;
        r.wb.gl_index = 6'h2a;
        r.exp_flush = 7'b1111010;
        r.exp_fetch.next_pc = NEXT_PC_JUMP;
        r.exp_fetch.sel_addr = SEL_EXECUTION;
        r.exp_ir.do_recover = 1'b1;
        r.exp_ir.recover_checkpoint = 3'd5;
        r.exp_wb.flush_gl = 1'b1;
        r.exp_wb.flush_gl_index = 6'h2a;
        rows.push_back(r);
        // same branch predicted correctly
        r.wb.correct_pred = 1'b1;
        r.wb.write_enable = 2'b01;
        r.exp_flush = '0;
        r.exp_fetch.next_pc = NEXT_PC_BP_OR_PC4;
        r.exp_fetch.sel_addr = SEL_DECODE;
        r.exp_ir.do_recover = 1'b0;
        r.exp_ir.delete_checkpoint = 1'b1;
        r.exp_wb = '0;
        r.exp_rr.write_enable = 2'b01;
        rows.push_back(r);
        // commit exception is masked in its own cycle
        r = idle_row();
        r.commit.valid = 1'b1;
        r.commit.xcpt = 1'b1;
        r.commit.write_enable = 1'b1;
        r.commit.retire = 2'b11;
        r.commit.regfile_we = 2'b11;
        r.exp_commit.enable_commit = 1'b0;
        rows.push_back(r);
        // held request shows the redirect of the previous cycle and no new one
        r.exp_commit.enable_commit = 1'b1;
        r.exp_commit.flush_gl_commit = 1'b1;
        r.exp_flush = 7'b1111100;
        r.exp_fetch.next_pc = NEXT_PC_JUMP;
        r.exp_fetch.sel_addr = SEL_CSR;
        r.exp_fetch.invalidate_buffer = 1'b1;
        r.exp_ir.enable_commit_update = 2'b11;
        r.exp_ir.recover_commit = 1'b1;
        rows.push_back(r);
        rows.push_back(idle_row());
        // stall causes removed one by one in priority order
        r = idle_row();
        r.csr.csr_stall = 1'b1;
        r.ir.full_iq = 2'b01;
        r.exe.stall = 1'b1;
        r.rr.gl_full = 1'b1;
        r.ir.empty_free_list = 1'b1;
        r.ir.out_of_checkpoints = 1'b1;
        r.exp_ctrl = 9'b111111100;
        r.exp_fetch.next_pc = NEXT_PC_KEEP_PC;
        rows.push_back(r);
        r.csr.csr_stall = 1'b0;
        r.exp_ctrl = 9'b111111000;
        rows.push_back(r);
        r.ir.full_iq = 2'b00;
        r.exe.stall = 1'b0;
        r.exp_ctrl = 9'b000111000;
        r.exp_flush = 7'b0001000;
        r.exp_fetch.next_pc = NEXT_PC_BP_OR_PC4;
        rows.push_back(r);
        r.rr.gl_full = 1'b0;
        r.exp_ctrl = 9'b000100000;
        r.exp_flush = '0;
        rows.push_back(r);
        r.ir.empty_free_list = 1'b0;
        r.miss = 1'b1;
        r.commit.stall_commit = 1'b1;
        r.exp_ctrl = 9'b100100010;
        r.exp_fetch.next_pc = NEXT_PC_KEEP_PC;
        r.exp_commit.enable_commit = 1'b0;
        rows.push_back(r);
        r = idle_row();
        r.ready = 1'b0;
        r.exp_ctrl = 9'b100000000;
        r.exp_fetch.next_pc = NEXT_PC_KEEP_PC;
        rows.push_back(r);
        // csr fence seen at decode and then pending
        r = idle_row();
        r.id.valid = 1'b1;
        r.id.stall_csr_fence = 1'b1;
        r.exp_flush = 7'b1000000;
        r.exp_fetch.next_pc = NEXT_PC_KEEP_PC;
        rows.push_back(r);
        r.id = '0;
        rows.push_back(r);
        // csr fence reaches commit
        r.commit.valid = 1'b1;
        r.commit.stall_csr_fence = 1'b1;
        r.exp_ctrl = 9'b100000000;
        r.exp_fetch.invalidate_buffer = 1'b1;
        rows.push_back(r);
        r = idle_row();
        r.exp_flush = 7'b1100000;
        r.exp_fetch.next_pc = NEXT_PC_JUMP;
        r.exp_fetch.sel_addr = SEL_CSR_RW;
        rows.push_back(r);
        rows.push_back(idle_row());
        // checkpoint, write enables from both sides and fence.i
        r = idle_row();
        r.ir.valid = 2'b11;
        r.ir.is_branch = 2'b10;
        r.wb.valid = 2'b10;
        r.wb.write_enable = 2'b10;
        r.commit.valid = 1'b1;
        r.commit.write_enable = 1'b1;
        r.commit.fence_i = 1'b1;
        r.exp_ir.do_checkpoint = 1'b1;
        r.exp_rr.write_enable = 2'b11;
        r.exp_fetch.invalidate_icache = 1'b1;
        r.exp_fetch.invalidate_buffer = 1'b1;
        rows.push_back(r);
        r.exe.stall = 1'b1;
        r.wb.valid = 2'b01;
        r.wb.write_enable = 2'b01;
        r.wb.correct_pred = 1'b1;
        r.commit = '0;
        r.exp_ctrl = 9'b000111000;
        r.exp_ir.do_checkpoint = 1'b0;
        r.exp_rr.write_enable = 2'b01;
        r.exp_fetch.invalidate_icache = 1'b0;
        r.exp_fetch.invalidate_buffer = 1'b0;
        rows.push_back(r);
        // csr exception blocks the commit write and redirects next cycle
        r = idle_row();
        r.commit.valid = 1'b1;
        r.commit.write_enable = 1'b1;
        r.csr.csr_exception = 1'b1;
        r.exp_commit.enable_commit = 1'b0;
        rows.push_back(r);
        r = idle_row();
        r.exp_flush = 7'b1111100;
        r.exp_fetch.next_pc = NEXT_PC_JUMP;
        r.exp_fetch.sel_addr = SEL_CSR;
        r.exp_ir.recover_commit = 1'b1;
        r.exp_commit.flush_gl_commit = 1'b1;
        rows.push_back(r);
        rows.push_back(idle_row());
    endtask

    initial begin
        int wait_cycles;
        rstn = 1'b0;
        check_en = 1'b0;
        row_idx = 0;
        cur = idle_row();
        build_table();
        // four rising edges in reset, release on the following falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            row_idx = i;
            cur = rows[i];
            check_en = 1'b1;
            @(negedge clk);
        end
        check_en = 1'b0;
        cur = idle_row();
        wait_cycles = 0;
        while (check_count < rows.size() && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (check_count < rows.size()) begin
            $display("checker stopped after %0d of %0d rows", check_count, rows.size());
            $display("Regression failed");
            $finish;
        end else begin
            $display("rows checked %0d, errors %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

//--- cu.f
source/cu_pkg.sv
source/redirect_tracker.sv
source/pc_select.sv
source/flush_ctrl.sv
source/stall_ctrl.sv
source/rename_commit_ctrl.sv
source/control_unit.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_control_unit.sv
